// File: testbench/call_unit_input.txt
# L pc sp | M addr byte | C exp_pc exp_sp exp_high_push exp_low_push | R exp_pc exp_sp
# all values hex, memory preloads come before the instruction that reads them
L 0100 fff0
M 0100 34
M 0101 12
# call 1234 from 0100, returns to 0102
C 1234 ffee 01 02
R 0102 fff0
M 0102 cd
M 0103 ab
C abcd ffee 01 04
# nested call from abcd
M abcd 78
M abce 56
C 5678 ffec ab cf
R abcf ffee
R 0104 fff0
# stack wraps below address 0000
L 80fe 0001
M 80fe 00
M 80ff 90
C 9000 ffff 81 00
R 8100 0001
# operand fetch wraps PC past ffff
L ffff 2000
M ffff 22
M 0000 11
C 1122 1ffe 00 01
R 0001 2000
# back to back calls without a return
L 4000 3000
M 4000 00
M 4001 50
C 5000 2ffe 40 02
M 5000 00
M 5001 60
C 6000 2ffc 50 02
R 5002 2ffe
R 4002 3000

// File: verilog.f
+incdir+include
hdl/xpt_pkg.sv
hdl/xpt_counter.sv
hdl/call_step_decoder.sv
hdl/ret_step_decoder.sv
hdl/pc_sp_regs.sv
hdl/call_unit_top.sv
testbench/tb_call_unit.sv

// File: Makefile
TOP = tb_call_unit
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module call_unit_top

clean:
	rm -rf obj_dir $(LOG)

// File: testbench/tb_call_unit.sv
/* testbench for call_unit_top, to be run from the project root so the data file path resolves
   memory is a 64 KB byte array read combinationally and every other command gets a stray start */
`timescale 1ns/1ps

`include "xpt_defines.svh"

module tb_call_unit import xpt_pkg::*; ();

    localparam int    DONE_TIMEOUT = 50;
    localparam string INPUT_FILE   = "testbench/call_unit_input.txt";

    logic     clk;
    logic     rst_n;
    logic     load_regs;
    addr_t    pc_init;
    addr_t    sp_init;
    logic     op_start;
    op_kind_t op_code;
    data_t    mem_rdata;
    logic     done;
    logic     busy;
    addr_t    pc;
    addr_t    sp;
    addr_t    mem_addr;
    data_t    mem_wdata;
    logic     mem_rd;
    logic     mem_wr;

    data_t mem [0:65535];
    addr_t wr_addr_q[$];
    data_t wr_data_q[$];

    addr_t model_pc;
    addr_t model_sp;
    int    cmd_count;

    call_unit_top u_call_unit_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_regs (load_regs),
        .pc_init   (pc_init),
        .sp_init   (sp_init),
        .op_start  (op_start),
        .op_code   (op_code),
        .mem_rdata (mem_rdata),
        .done      (done),
        .busy      (busy),
        .pc        (pc),
        .sp        (sp),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    assign mem_rdata = mem[mem_addr]; // same-cycle read

    // a write lands at the rising edge while mem_wr is high and is logged for the push checks
    always @(posedge clk) begin
        if (mem_wr) begin
            mem[mem_addr] = mem_wdata;
            wr_addr_q.push_back(mem_addr);
            wr_data_q.push_back(mem_wdata);
        end
    end

    task automatic fail_now(input string msg);
        $display("%0t ns: %s", $time, msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s = %h, expected %h", $time, name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "address mismatch");
        end
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s = %h, expected %h", $time, name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s = %b, expected %b", $time, name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "strobe mismatch");
        end
    endtask

    task automatic check_idle_outputs();
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);
        check_bit("mem_rd", mem_rd, 1'b0);
        check_bit("mem_wr", mem_wr, 1'b0);
        check_addr("pc", pc, model_pc);
        check_addr("sp", sp, model_sp);
    endtask

    task automatic reset_dut();
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 check_idle_outputs();
        #1 rst_n = 1'b1;
        @(posedge clk);
        #1 check_idle_outputs(); // PC and SP stay 0 until load_regs
        #1;
    endtask

    task automatic load_registers(input addr_t new_pc, input addr_t new_sp);
        pc_init   = new_pc;
        sp_init   = new_sp;
        load_regs = 1'b1;
        @(posedge clk);
        #1 check_addr("pc", pc, new_pc);
        check_addr("sp", sp, new_sp);
        #1 load_regs = 1'b0;
        model_pc = new_pc;
        model_sp = new_sp;
    endtask

    task automatic idle_gap();
        int gap;
        gap = $urandom % 4;
        repeat (gap) begin
            @(posedge clk);
            #1 check_bit("busy", busy, 1'b0);
            check_bit("done", done, 1'b0);
            #1;
        end
    endtask

    // CALL writes on its W1 steps 5 and 8 and RET never writes
    function automatic logic write_expected(input op_kind_t op, input int step);
        return (op == OP_CALL) && (step == 5 || step == 8);
    endfunction

    // both instructions read memory on steps 1 and 2 only
    function automatic logic read_expected(input int step);
        return (step == 1 || step == 2);
    endfunction

    task automatic run_instruction(input op_kind_t op, input logic stray_start,
                                   input addr_t exp_pc, input addr_t exp_sp,
                                   input data_t exp_hi, input data_t exp_lo);
        int cycles;
        int last_step;
        int exp_writes;
        last_step  = (op == OP_CALL) ? `CALL_LAST_STEP : `RET_LAST_STEP;
        exp_writes = (op == OP_CALL) ? 2 : 0;
        wr_addr_q.delete();
        wr_data_q.delete();
        op_code  = op;
        op_start = 1'b1;
        cycles   = -1;
        do begin
            @(posedge clk);
            #1 cycles++;
            if (cycles > DONE_TIMEOUT) begin
                fail_now("done never came after op_start");
            end
            // cycles counts edges after the one that took op_start, so step = cycles + 1
            check_bit("done", done, cycles == last_step);
            check_bit("busy", busy, cycles < last_step);
            check_bit("mem_wr", mem_wr, write_expected(op, cycles + 1));
            check_bit("mem_rd", mem_rd, read_expected(cycles + 1));
            #1;
            if (stray_start && cycles == 0) begin
                op_code = (op == OP_CALL) ? OP_RET : OP_CALL;
            end else begin
                op_start = 1'b0;
            end
        end while (!done);

        check_addr("pc", pc, exp_pc);
        check_addr("sp", sp, exp_sp);
        if (wr_addr_q.size() != exp_writes) begin
            fail_now($sformatf("expected %0d memory writes, saw %0d",
                               exp_writes, wr_addr_q.size()));
        end
        if (op == OP_CALL) begin
            check_addr("mem_addr of high push", wr_addr_q[0], addr_t'(model_sp - 16'd1));
            check_data("mem_wdata of high push", wr_data_q[0], exp_hi);
            check_addr("mem_addr of low push", wr_addr_q[1], addr_t'(model_sp - 16'd2));
            check_data("mem_wdata of low push", wr_data_q[1], exp_lo);
        end
        model_pc = exp_pc;
        model_sp = exp_sp;
    endtask

    // a start with OP_NONE must leave the unit idle for the whole timeout
    task automatic expect_no_done();
        op_code  = OP_NONE;
        op_start = 1'b1;
        @(posedge clk);
        #2 op_start = 1'b0;
        repeat (DONE_TIMEOUT) begin
            @(posedge clk);
            #1 check_idle_outputs();
            #1;
        end
    endtask

    initial begin
        int           fd;
        int           n;
        logic [7:0]   kind;
        logic [1023:0] line_buf;
        addr_t        a;
        addr_t        b;
        data_t        d1;
        data_t        d2;

        void'($urandom(72));
        rst_n     = 1'b0;
        load_regs = 1'b0;
        pc_init   = '0;
        sp_init   = '0;
        op_start  = 1'b0;
        op_code   = OP_NONE;
        model_pc  = '0;
        model_sp  = '0;
        cmd_count  = 0;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = data_t'(i[15:8] ^ i[7:0] ^ 8'hc3);
        end

        reset_dut();

        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            fail_now("cannot open the command file");
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, " %c", kind);
            if (n != 1) begin
                break;
            end
            case (kind)
                "#": n = $fgets(line_buf, fd);
                "L": begin
                    n = $fscanf(fd, "%h %h", a, b);
                    load_registers(a, b);
                end
                "M": begin
                    n = $fscanf(fd, "%h %h", a, d1);
                    mem[a] = d1;
                end
                "C": begin
                    n = $fscanf(fd, "%h %h %h %h", a, b, d1, d2);
                    run_instruction(OP_CALL, cmd_count[0], a, b, d1, d2);
                    cmd_count++;
                    idle_gap();
                end
                "R": begin
                    n = $fscanf(fd, "%h %h", a, b);
                    run_instruction(OP_RET, cmd_count[0], a, b, 8'h00, 8'h00);
                    cmd_count++;
                    idle_gap();
                end
                default: fail_now("unknown command letter in the command file");
            endcase
        end
        $fclose(fd);

        expect_no_done();

        if (cmd_count > 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("no instruction was run from the command file");
            $display("*** TEST FAILED ***");
            $fatal(1, "empty run");
        end
    end

endmodule

// File: hdl/call_unit_top.sv
/* CALL nn / RET sequencer, opcode fetch and decode happen outside
   memory must answer reads in the same cycle as the address */
`timescale 1ns/1ps

module call_unit_top import xpt_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     load_regs,
    input  addr_t    pc_init,
    input  addr_t    sp_init,
    input  logic     op_start,
    input  op_kind_t op_code,
    input  data_t    mem_rdata,
    output logic     done,
    output logic     busy,
    output addr_t    pc,
    output addr_t    sp,
    output addr_t    mem_addr,
    output data_t    mem_wdata,
    output logic     mem_rd,
    output logic     mem_wr
);

    xpt_t     xpt;
    op_kind_t active_op;
    logic     call_last;
    logic     ret_last;

    logic read_operand_low;
    logic read_operand_high;
    logic dec_sp;
    logic addr_sel_sp;
    logic data_sel_pc_high;
    logic data_sel_pc_low;
    logic write_phase_w0;
    logic write_phase_w1;
    logic write_phase_w2;
    logic load_pc_operand;
    logic pop_pc_low;
    logic pop_pc_high;

    xpt_counter u_xpt_counter (
        .clk       (clk),
        .rst_n     (rst_n),
        .op_start  (op_start),
        .op_code   (op_code),
        .call_last (call_last),
        .ret_last  (ret_last),
        .xpt       (xpt),
        .active_op (active_op),
        .busy      (busy),
        .done      (done)
    );

    call_step_decoder u_call_step_decoder (
        .active_op         (active_op),
        .xpt               (xpt),
        .read_operand_low  (read_operand_low),
        .read_operand_high (read_operand_high),
        .dec_sp            (dec_sp),
        .addr_sel_sp       (addr_sel_sp),
        .data_sel_pc_high  (data_sel_pc_high),
        .data_sel_pc_low   (data_sel_pc_low),
        .write_phase_w0    (write_phase_w0),
        .write_phase_w1    (write_phase_w1),
        .write_phase_w2    (write_phase_w2),
        .load_pc_operand   (load_pc_operand),
        .call_last         (call_last)
    );

    ret_step_decoder u_ret_step_decoder (
        .active_op   (active_op),
        .xpt         (xpt),
        .pop_pc_low  (pop_pc_low),
        .pop_pc_high (pop_pc_high),
        .ret_last    (ret_last)
    );

    pc_sp_regs u_pc_sp_regs (
        .clk               (clk),
        .rst_n             (rst_n),
        .load_regs         (load_regs),
        .pc_init           (pc_init),
        .sp_init           (sp_init),
        .read_operand_low  (read_operand_low),
        .read_operand_high (read_operand_high),
        .dec_sp            (dec_sp),
        .addr_sel_sp       (addr_sel_sp),
        .data_sel_pc_high  (data_sel_pc_high),
        .data_sel_pc_low   (data_sel_pc_low),
        .write_phase_w0    (write_phase_w0),
        .write_phase_w1    (write_phase_w1),
        .write_phase_w2    (write_phase_w2),
        .load_pc_operand   (load_pc_operand),
        .pop_pc_low        (pop_pc_low),
        .pop_pc_high       (pop_pc_high),
        .mem_rdata         (mem_rdata),
        .pc                (pc),
        .sp                (sp),
        .mem_addr          (mem_addr),
        .mem_wdata         (mem_wdata),
        .mem_rd            (mem_rd),
        .mem_wr            (mem_wr)
    );

endmodule

// File: hdl/pc_sp_regs.sv
/* PC, SP and operand registers with the memory bus drive
   reads are combinational, load_regs is honoured only while no step strobe is active */
`timescale 1ns/1ps

module pc_sp_regs import xpt_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  load_regs,
    input  addr_t pc_init,
    input  addr_t sp_init,
    input  logic  read_operand_low,
    input  logic  read_operand_high,
    input  logic  dec_sp,
    input  logic  addr_sel_sp,
    input  logic  data_sel_pc_high,
    input  logic  data_sel_pc_low,
    input  logic  write_phase_w0,
    input  logic  write_phase_w1,
    input  logic  write_phase_w2,
    input  logic  load_pc_operand,
    input  logic  pop_pc_low,
    input  logic  pop_pc_high,
    input  data_t mem_rdata,
    output addr_t pc,
    output addr_t sp,
    output addr_t mem_addr,
    output data_t mem_wdata,
    output logic  mem_rd,
    output logic  mem_wr
);

    data_t operand_low;
    data_t operand_high;
    logic  in_step;
    logic  wr_window;
    logic  pop_step;

    assign pop_step = pop_pc_low | pop_pc_high;

    // every CALL and RET step raises at least one of these
    assign in_step = read_operand_low | read_operand_high | dec_sp | addr_sel_sp | pop_step;

    assign wr_window = write_phase_w0 | write_phase_w1 | write_phase_w2;

    assign mem_addr = (addr_sel_sp | pop_step) ? sp : pc;
    assign mem_rd   = read_operand_low | read_operand_high | pop_step;
    assign mem_wr   = write_phase_w1; // W0 and W2 keep address and data steady around it

    always_comb begin
        mem_wdata = '0;
        if (wr_window) begin
            if (data_sel_pc_high) begin
                mem_wdata = pc[15:8];
            end else if (data_sel_pc_low) begin
                mem_wdata = pc[7:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (read_operand_low | read_operand_high) begin
            pc <= pc + 1'b1; // walk over the two target bytes
        end else if (load_pc_operand) begin
            pc <= {operand_high, operand_low};
        end else if (pop_pc_low) begin
            pc[7:0] <= mem_rdata;
        end else if (pop_pc_high) begin
            pc[15:8] <= mem_rdata;
        end else if (load_regs && !in_step) begin
            pc <= pc_init;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sp <= '0;
        end else if (dec_sp) begin
            sp <= sp - 1'b1;
        end else if (pop_step) begin
            sp <= sp + 1'b1;
        end else if (load_regs && !in_step) begin
            sp <= sp_init;
        end
    end

    // call target, consumed at the last CALL step
    always_ff @(posedge clk) begin
        if (read_operand_low) begin
            operand_low <= mem_rdata;
        end
        if (read_operand_high) begin
            operand_high <= mem_rdata;
        end
    end

endmodule

// File: hdl/ret_step_decoder.sv
/* step decoder of RET, active only while OP_RET runs
   pops PC low byte first */
`timescale 1ns/1ps

`include "xpt_defines.svh"

module ret_step_decoder import xpt_pkg::*; (
    input  op_kind_t active_op,
    input  xpt_t     xpt,
    output logic     pop_pc_low,
    output logic     pop_pc_high,
    output logic     ret_last
);

    logic                     ret_en;
    logic [2**`XPT_WIDTH-1:0] step;

    assign ret_en = (active_op == OP_RET);

    always_comb begin
        step = '0;
        if (ret_en) begin
            step[xpt] = 1'b1;
        end
    end

    assign pop_pc_low  = step[1];
    assign pop_pc_high = step[`RET_LAST_STEP];
    assign ret_last    = step[`RET_LAST_STEP]; // the high byte pop ends RET

endmodule

// File: hdl/call_step_decoder.sv
/* step decoder of CALL nn, active only while OP_CALL runs
   steps 4 to 6 push PC high, steps 7 to 9 push PC low, each as a W0/W1/W2 write */
`timescale 1ns/1ps

`include "xpt_defines.svh"

module call_step_decoder import xpt_pkg::*; (
    input  op_kind_t active_op,
    input  xpt_t     xpt,
    output logic     read_operand_low,
    output logic     read_operand_high,
    output logic     dec_sp,
    output logic     addr_sel_sp,
    output logic     data_sel_pc_high,
    output logic     data_sel_pc_low,
    output logic     write_phase_w0,
    output logic     write_phase_w1,
    output logic     write_phase_w2,
    output logic     load_pc_operand,
    output logic     call_last
);

    logic                        call_en;
    logic [2**`XPT_WIDTH-1:0]    step;

    assign call_en = (active_op == OP_CALL);

    // one-hot view of the current step, all zero when another opcode runs
    always_comb begin
        step = '0;
        if (call_en) begin
            step[xpt] = 1'b1;
        end
    end

    // operand fetch from the bytes after the opcode
    assign read_operand_low  = step[1];
    assign read_operand_high = step[2];

    // pre-decrement before the first push, again between the two pushes
    assign dec_sp = step[3] | step[6];

    // SP addresses memory for the whole push phase
    assign addr_sel_sp = step[4] | step[5] | step[6] | step[7] | step[8] | step[9];

    assign data_sel_pc_high = step[4] | step[5] | step[6];
    assign data_sel_pc_low  = step[7] | step[8] | step[9];

    assign write_phase_w0 = step[4] | step[7]; // setup
    assign write_phase_w1 = step[5] | step[8]; // the actual write
    assign write_phase_w2 = step[6] | step[9]; // hold

    // the jump and the end of the instruction share the final step
    assign load_pc_operand = step[`CALL_LAST_STEP];
    assign call_last       = step[`CALL_LAST_STEP];

endmodule

// File: hdl/xpt_counter.sv
/* steps XPT from 1 each cycle until a decoder flags the last step
   a start while busy or with OP_NONE is dropped */
`timescale 1ns/1ps

module xpt_counter import xpt_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     op_start,
    input  op_kind_t op_code,
    input  logic     call_last,
    input  logic     ret_last,
    output xpt_t     xpt,
    output op_kind_t active_op,
    output logic     busy,
    output logic     done
);

    logic step_last;
    logic start_ok;

    assign busy      = (active_op != OP_NONE);
    assign step_last = call_last | ret_last;

    // only an idle unit takes a real instruction
    assign start_ok = op_start && !busy && (op_code != OP_NONE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            xpt       <= '0;
            active_op <= OP_NONE;
        end else if (start_ok) begin
            xpt       <= xpt_t'(1);
            active_op <= op_code;
        end else if (busy) begin
            if (step_last) begin
                xpt       <= '0; // back to idle at the end of the last step
                active_op <= OP_NONE;
            end else begin
                xpt <= xpt + 1'b1;
            end
        end
    end

    // done lands in the first idle cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= busy & step_last;
        end
    end

endmodule

// File: hdl/xpt_pkg.sv
/* types shared by the call/return sequencer
   widths come from xpt_defines.svh, so the include directory must be on the search path */
package xpt_pkg;

`include "xpt_defines.svh"

    // instructions the unit can run, OP_NONE doubles as the idle marker
    typedef enum logic [1:0] {
        OP_NONE = 2'd0,
        OP_CALL = 2'd1,
        OP_RET  = 2'd2
    } op_kind_t;

    typedef logic [`XPT_WIDTH-1:0]  xpt_t;  // timing step number
    typedef logic [`ADDR_WIDTH-1:0] addr_t; // address, PC or SP
    typedef logic [`DATA_WIDTH-1:0] data_t; // one memory byte

endpackage

// File: include/xpt_defines.svh
/* widths and step numbers of the call/return sequencer
   step numbers count from 1, step 0 is the idle value of XPT */
`ifndef XPT_DEFINES_SVH
`define XPT_DEFINES_SVH

// step counter width, enough for the 9 steps of CALL
`define XPT_WIDTH 4

// memory bus
`define ADDR_WIDTH 16
`define DATA_WIDTH 8

// last timing step of each instruction
`define CALL_LAST_STEP 9
`define RET_LAST_STEP 2

`endif
